// File: run_sim.sh
#!/bin/sh
# Compiles the bring-up monitor testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing \
	--top-module tb_bringup \
	-f sources.f \
	--Mdir obj_dir \
	-o tb_bringup_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

output=$(./obj_dir/tb_bringup_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "^TEST RESULT: PASS$"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: source/bringup_pkg.sv
// Character codes are plain ASCII and the decay width limits DECAY_MAX to 7
package bringup_pkg;

	// one serial character on the UART
	typedef logic [7:0] uart_byte_t;

	// per-pin countdown of recent activity
	typedef logic [2:0] decay_t;

	// reloaded on every synchronized pin edge
	localparam decay_t DECAY_MAX = 3'd7;

	// report characters
	localparam uart_byte_t CHAR_ACTIVE = 8'h23; // '#'
	localparam uart_byte_t CHAR_QUIET  = 8'h2E; // '.'
	localparam uart_byte_t CHAR_CR     = 8'h0D;
	localparam uart_byte_t CHAR_LF     = 8'h0A;

	// line scanner states
	typedef enum logic [1:0] {
		SCAN_IDLE = 2'd0, // waiting for a scan pulse
		SCAN_SEND = 2'd1, // load next character
		SCAN_WAIT = 2'd2, // write strobe cycle
		SCAN_HOLD = 2'd3  // wait for transmitter to finish
	} scan_state_t;

endpackage

// File: source/bringup_top.sv
// Pins are sampled as asynchronous inputs and the divider parameters assume one clock domain
`timescale 1ns/1ps

module bringup_top #(
	parameter int NUM_PINS         = 16,
	parameter int CLOCKS_PER_BAUD  = 104,
	parameter int CLOCKS_PER_DECAY = 12000,
	parameter int CLOCKS_PER_SCAN  = 1200000
) (
	input  logic                clock,
	input  logic                arst_n_i,
	input  logic [NUM_PINS-1:0] pins_i,
	output logic                uart_tx_o
);

	logic                decay_pulse;
	logic                scan_pulse;
	logic [NUM_PINS-1:0] active;
	logic                tx_write;
	logic [7:0]          tx_data;
	logic                tx_busy;

	pulse_gen #(.PERIOD(CLOCKS_PER_DECAY)) i_decay_pulse ( // activity decay tick
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.pulse_o  (decay_pulse)
	);

	pulse_gen #(.PERIOD(CLOCKS_PER_SCAN)) i_scan_pulse ( // report rate
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.pulse_o  (scan_pulse)
	);

	pin_activity_monitor #(.NUM_PINS(NUM_PINS)) i_pin_activity_monitor (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.pins_i   (pins_i),
		.decay_i  (decay_pulse),
		.active_o (active)
	);

	line_scanner #(.NUM_PINS(NUM_PINS)) i_line_scanner (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.scan_i   (scan_pulse),
		.active_i (active),
		.write_o  (tx_write),
		.data_o   (tx_data),
		.busy_i   (tx_busy)
	);

	uart_tx #(.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)) i_uart_tx (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.write_i  (tx_write),
		.data_i   (tx_data),
		.busy_o   (tx_busy),
		.tx_o     (uart_tx_o)
	);

endmodule

// File: source/line_scanner.sv
// One line per accepted scan pulse and pulses arriving while a line is in flight are dropped
`timescale 1ns/1ps

module line_scanner import bringup_pkg::*; #(
	parameter int NUM_PINS = 16
) (
	input  logic                clock,
	input  logic                arst_n_i,
	input  logic                scan_i,
	input  logic [NUM_PINS-1:0] active_i,
	output logic                write_o,
	output uart_byte_t          data_o,
	input  logic                busy_i
);

	localparam int NUM_CHARS = NUM_PINS + 2; // pins plus CR and LF
	localparam int IW = $clog2(NUM_CHARS);
	localparam logic [IW-1:0] IDX_CR = IW'(NUM_PINS);
	localparam logic [IW-1:0] IDX_LF = IW'(NUM_PINS + 1);

	scan_state_t         state_q;
	logic [IW-1:0]       idx_q;    // character position in the line
	logic [NUM_PINS-1:0] snap_q;   // frozen pin states, current pin in bit 0
	uart_byte_t          data_q;
	uart_byte_t          next_char;
	logic                start;
	logic                advance;

	assign start   = (state_q == SCAN_IDLE) && scan_i;
	assign advance = (state_q == SCAN_HOLD) && !busy_i;

	// character for the current position
	always_comb begin
		if (idx_q == IDX_LF)
			next_char = CHAR_LF;
		else if (idx_q == IDX_CR)
			next_char = CHAR_CR;
		else if (snap_q[0])
			next_char = CHAR_ACTIVE;
		else
			next_char = CHAR_QUIET;
	end

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= SCAN_IDLE;
			idx_q   <= '0;
		end else begin
			case (state_q)
				SCAN_IDLE: begin
					if (scan_i) begin
						idx_q   <= '0;
						state_q <= SCAN_SEND;
					end
				end
				SCAN_SEND: state_q <= SCAN_WAIT;
				SCAN_WAIT: state_q <= SCAN_HOLD; // busy not valid yet
				SCAN_HOLD: begin
					if (!busy_i) begin
						if (idx_q == IDX_LF) begin
							state_q <= SCAN_IDLE; // line complete
						end else begin
							idx_q   <= idx_q + 1'b1;
							state_q <= SCAN_SEND;
						end
					end
				end
				default: state_q <= SCAN_IDLE;
			endcase
		end
	end

	// The snapshot shifts one pin per character so the report keeps
	// pin-index order without a wide mux on the index.
	always_ff @(posedge clock) begin
		if (start)
			snap_q <= active_i;
		else if (advance)
			snap_q <= snap_q >> 1;
		if (state_q == SCAN_SEND)
			data_q <= next_char;
	end

	assign write_o = (state_q == SCAN_WAIT); // exactly one cycle per byte
	assign data_o  = data_q;

endmodule

// File: source/pin_activity_monitor.sv
// Pins may be asynchronous and must hold each level for at least two clocks to be seen
`timescale 1ns/1ps

module pin_activity_monitor import bringup_pkg::*; #(
	parameter int NUM_PINS = 16
) (
	input  logic                clock,
	input  logic                arst_n_i,
	input  logic [NUM_PINS-1:0] pins_i,
	input  logic                decay_i,
	output logic [NUM_PINS-1:0] active_o
);

	for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
		logic   meta_q;   // first synchronizer stage
		logic   sync_q;   // second synchronizer stage
		logic   prev_q;   // last synchronized level
		logic   pin_edge;
		decay_t count_q;

		// two-flop synchronizer plus edge history
		always_ff @(posedge clock or negedge arst_n_i) begin
			if (!arst_n_i) begin
				meta_q <= 1'b0;
				sync_q <= 1'b0;
				prev_q <= 1'b0;
			end else begin
				meta_q <= pins_i[i];
				sync_q <= meta_q;
				prev_q <= sync_q;
			end
		end

		assign pin_edge = sync_q ^ prev_q; // either direction counts

		// An edge restarts the countdown even when a decay tick lands in the
		// same cycle, so a pin that keeps toggling never drops out.
		always_ff @(posedge clock or negedge arst_n_i) begin
			if (!arst_n_i) begin
				count_q <= '0;
			end else if (pin_edge) begin
				count_q <= DECAY_MAX;
			end else if (decay_i && (count_q != '0)) begin
				count_q <= count_q - 1'b1;
			end
		end

		assign active_o[i] = (count_q != '0);
	end

endmodule

// File: source/pulse_gen.sv
// PERIOD must be at least 1 and the first pulse comes PERIOD clocks after reset release
`timescale 1ns/1ps

module pulse_gen #(
	parameter int PERIOD = 1000
) (
	input  logic clock,
	input  logic arst_n_i,
	output logic pulse_o
);

	localparam int CW = (PERIOD > 1) ? $clog2(PERIOD) : 1;
	localparam logic [CW-1:0] LOAD = CW'(PERIOD - 1);

	logic [CW-1:0] count_q;
	logic          pulse_q;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count_q <= LOAD;
			pulse_q <= 1'b0;
		end else begin
			pulse_q <= (count_q == '0); // one cycle, on the wrap
			if (count_q == '0)
				count_q <= LOAD;
			else
				count_q <= count_q - 1'b1;
		end
	end

	assign pulse_o = pulse_q;

endmodule

// File: source/uart_tx.sv
// 8N1 only and a write while busy_o is high is dropped, so callers must wait for busy_o low
`timescale 1ns/1ps

module uart_tx import bringup_pkg::*; #(
	parameter int CLOCKS_PER_BAUD = 104
) (
	input  logic       clock,
	input  logic       arst_n_i,
	input  logic       write_i,
	input  uart_byte_t data_i,
	output logic       busy_o,
	output logic       tx_o
);

	localparam int BW = (CLOCKS_PER_BAUD > 1) ? $clog2(CLOCKS_PER_BAUD) : 1;
	localparam logic [BW-1:0] BAUD_LOAD = BW'(CLOCKS_PER_BAUD - 1);

	logic [BW-1:0] baud_q;  // clocks left in the current bit
	logic [3:0]    bits_q;  // bits left in the frame
	logic [9:0]    shift_q; // stop, data, start with LSB on the line
	logic          baud_tick;

	assign baud_tick = (baud_q == '0);
	assign busy_o    = (bits_q != 4'd0);
	assign tx_o      = shift_q[0];

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			baud_q  <= '0;
			bits_q  <= 4'd0;
			shift_q <= '1; // line idles high
		end else if (!busy_o) begin
			if (write_i) begin
				shift_q <= {1'b1, data_i, 1'b0};
				bits_q  <= 4'd10;
				baud_q  <= BAUD_LOAD;
			end
		end else if (baud_tick) begin
			// ones shift in behind the stop bit, so the line ends idle
			shift_q <= {1'b1, shift_q[9:1]};
			bits_q  <= bits_q - 1'b1;
			baud_q  <= BAUD_LOAD;
		end else begin
			baud_q <= baud_q - 1'b1;
		end
	end

endmodule

// File: sources.f
source/bringup_pkg.sv
source/pulse_gen.sv
source/pin_activity_monitor.sv
source/uart_tx.sv
source/line_scanner.sv
source/bringup_top.sv
testbench/tb_bringup.sv

// File: testbench/tb_bringup.sv
// Assumes CLOCKS_PER_BAUD is even and that NUM_PINS fits the 16-bit random mask generator
`timescale 1ns/1ps

module tb_bringup;

	localparam int NUM_PINS         = 16;
	localparam int CLOCKS_PER_BAUD  = 4;
	localparam int CLOCKS_PER_DECAY = 20;
	localparam int CLOCKS_PER_SCAN  = 300;
	localparam int RESET_CYCLES     = 5;
	localparam int DECAY_STEPS      = 7;  // countdown loaded on each pin edge
	localparam int NUM_PHASES       = 6;  // last one is the quiet phase
	localparam int LINES_PER_PHASE  = 3;
	localparam int LINE_CYCLES      = (NUM_PINS + 2) * 10 * CLOCKS_PER_BAUD;
	localparam int DECAY_LIMIT      = DECAY_STEPS * CLOCKS_PER_DECAY + CLOCKS_PER_SCAN;
	localparam int WATCHDOG_CYCLES  = RESET_CYCLES
		+ NUM_PHASES * LINES_PER_PHASE * LINE_CYCLES * 2;
	localparam logic [7:0] ACTIVE_CH = 8'h23; // '#'
	localparam logic [7:0] QUIET_CH  = 8'h2E; // '.'
	localparam logic [7:0] CR_CH     = 8'h0D;
	localparam logic [7:0] LF_CH     = 8'h0A;

	logic                clock;
	logic                arst_n_i;
	logic [NUM_PINS-1:0] pins_i;
	logic                uart_tx_o;

	logic [15:0]         lfsr_state;
	logic [31:0]         rnd;
	int                  cycle;
	int                  release_cycle;
	int                  last_edge_cycle;
	int                  phase_idx;
	logic [NUM_PINS-1:0] phase_mask [NUM_PHASES];
	int                  phase_started [NUM_PHASES]; // lines that began in each phase
	int                  phase_lines [NUM_PHASES];   // lines that completed
	int                  checked_lines [NUM_PHASES];
	int                  quiet_lines;
	int                  lines_total;

	// receiver state
	logic [7:0]          rx_char;
	int                  rx_start;
	int                  rx_pos;
	int                  line_phase;
	logic                line_checked;
	logic                line_quiet;

	bringup_top #(
		.NUM_PINS         (NUM_PINS),
		.CLOCKS_PER_BAUD  (CLOCKS_PER_BAUD),
		.CLOCKS_PER_DECAY (CLOCKS_PER_DECAY),
		.CLOCKS_PER_SCAN  (CLOCKS_PER_SCAN)
	) i_bringup_top (
		.clock     (clock),
		.arst_n_i  (arst_n_i),
		.pins_i    (pins_i),
		.uart_tx_o (uart_tx_o)
	);

	always #50 clock = ~clock; // 100 ns period

	always @(posedge clock) cycle <= cycle + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[FAIL] %s expected 0x%0h got 0x%0h", name, expected, actual));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic take_random(input int nbits, output logic [31:0] value);
		int b;
		value = '0;
		for (b = 0; b < nbits; b++) begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// start bit found on a falling edge, then every bit sampled near its middle
	task automatic receive_byte(output logic [7:0] ch, output int start_cycle);
		int b;
		@(negedge clock);
		while (uart_tx_o !== 1'b0)
			@(negedge clock);
		start_cycle = cycle;
		repeat (CLOCKS_PER_BAUD / 2) @(negedge clock);
		check_value("uart_tx_o start bit", 32'(0), 32'(uart_tx_o));
		for (b = 0; b < 8; b++) begin
			repeat (CLOCKS_PER_BAUD) @(negedge clock);
			ch[b] = uart_tx_o; // LSB first
		end
		repeat (CLOCKS_PER_BAUD) @(negedge clock);
		check_value("uart_tx_o stop bit", 32'(1), 32'(uart_tx_o));
	endtask

	task automatic check_pin_char(input int pos, input logic [7:0] ch);
		logic [7:0] expected;
		check_value($sformatf("uart char class for pin %0d", pos), 32'(1),
			32'((ch == ACTIVE_CH) || (ch == QUIET_CH)));
		if (line_checked) begin
			expected = phase_mask[line_phase][pos] ? ACTIVE_CH : QUIET_CH;
			check_value($sformatf("uart char for pin %0d", pos), 32'(expected), 32'(ch));
		end
		if (line_quiet)
			check_value($sformatf("uart char for decayed pin %0d", pos),
				32'(QUIET_CH), 32'(ch));
	endtask

	initial begin : uart_receiver
		rx_pos = 0;
		wait (arst_n_i === 1'b1);
		forever begin
			receive_byte(rx_char, rx_start);
			if (rx_pos == 0) begin
				if (lines_total == 0)
					check_value("uart_tx_o idle before first scan", 32'(1),
						32'((rx_start - release_cycle) >= CLOCKS_PER_SCAN));
				line_phase = phase_idx;
				phase_started[line_phase]++;
				line_checked = (phase_started[line_phase] >= 2); // skip the transition line
				line_quiet = ((rx_start - last_edge_cycle) > DECAY_LIMIT);
			end
			if (rx_pos < NUM_PINS)
				check_pin_char(rx_pos, rx_char);
			else if (rx_pos == NUM_PINS)
				check_value("uart char CR", 32'(CR_CH), 32'(rx_char));
			else
				check_value("uart char LF", 32'(LF_CH), 32'(rx_char));
			if (rx_pos == NUM_PINS + 1) begin
				rx_pos = 0;
				lines_total++;
				phase_lines[line_phase]++;
				if (line_checked)
					checked_lines[line_phase]++;
				if (line_quiet)
					quiet_lines++;
			end else begin
				rx_pos++;
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		abort_run($sformatf("timeout after %0d cycles with %0d of %0d lines received",
			WATCHDOG_CYCLES, lines_total, NUM_PHASES * LINES_PER_PHASE));
	end

	initial begin : stimulus
		clock = 1'b0;
		arst_n_i = 1'b0;
		pins_i = '0;
		cycle = 0;
		lfsr_state = 16'd52589;
		last_edge_cycle = 0;
		phase_idx = 0;
		quiet_lines = 0;
		lines_total = 0;
		for (int p = 0; p < NUM_PHASES; p++) begin
			phase_started[p] = 0;
			phase_lines[p] = 0;
			checked_lines[p] = 0;
			phase_mask[p] = '0;
		end

		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_value("uart_tx_o in reset", 32'(1), 32'(uart_tx_o));
		end
		arst_n_i = 1'b1;
		release_cycle = cycle;

		for (int p = 0; p < NUM_PHASES; p++) begin
			if (p < NUM_PHASES - 1) begin
				take_random(NUM_PINS, rnd);
				phase_mask[p] = rnd[NUM_PINS-1:0];
			end
			phase_idx = p;
			while (phase_lines[p] < LINES_PER_PHASE) begin
				repeat (3) @(negedge clock);
				if (phase_mask[p] != '0) begin
					pins_i = pins_i ^ phase_mask[p]; // masked pins flip together
					last_edge_cycle = cycle;
				end
			end
		end

		for (int p = 0; p < NUM_PHASES; p++)
			check_value($sformatf("checked lines in phase %0d", p), 32'(1),
				32'(checked_lines[p] >= 1));
		check_value("lines received", 32'(NUM_PHASES * LINES_PER_PHASE), 32'(lines_total));
		check_value("decayed lines seen", 32'(1), 32'(quiet_lines >= 1));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
